//--- byteStage/prfByteBank.sv
`timescale 1ns/1ps
// Byte-wide register bank
module prfByteBank
	import prfPkg::*;
#(
	parameter int numLanes = NUM_LANES_DEF,
	parameter int numRegs  = NUM_REGS_DEF
)
(
	input  logic                clk,
	input  logic                rstN_i,

	// Source reads, one pair per lane
	input  physTag_t            rdTag1_i  [0:numLanes-1],
	input  physTag_t            rdTag2_i  [0:numLanes-1],
	output regByte_t            rdByte1_o [0:numLanes-1],
	output regByte_t            rdByte2_o [0:numLanes-1],

	// Lane writes
	input  logic [numLanes-1:0] wrEn_i,
	input  physTag_t            wrTag_i   [0:numLanes-1],
	input  regByte_t            wrByte_i  [0:numLanes-1],

	// Debug access
	input  logic                dbgWe_i,
	input  physTag_t            dbgTag_i,
	input  regByte_t            dbgByte_i,
	output regByte_t            dbgByte_o
);

	regByte_t regs [0:numRegs-1];

	// Asynchronous reads
	always_comb
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			// Tags past the end of the file read as zero
			if (int'(rdTag1_i[l]) < numRegs)
			begin
				rdByte1_o[l] = regs[rdTag1_i[l]];
			end
			else
			begin
				rdByte1_o[l] = '0;
			end

			if (int'(rdTag2_i[l]) < numRegs)
			begin
				rdByte2_o[l] = regs[rdTag2_i[l]];
			end
			else
			begin
				rdByte2_o[l] = '0;
			end
		end
	end

	assign dbgByte_o = (int'(dbgTag_i) < numRegs) ? regs[dbgTag_i] : '0;

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			for (int r = 0; r < numRegs; r++)
			begin
				regs[r] <= '0;
			end
		end
		else
		begin
			// Debug goes first so that lane writes override it
			if (dbgWe_i && int'(dbgTag_i) < numRegs)
			begin
				regs[dbgTag_i] <= dbgByte_i;
			end

			// Lane order, highest lane wins
			for (int l = 0; l < numLanes; l++)
			begin
				if (wrEn_i[l] && int'(wrTag_i[l]) < numRegs)
				begin
					regs[wrTag_i[l]] <= wrByte_i[l];
				end
			end
		end
	end

endmodule

//--- byteStage/prfByteStage.sv
`timescale 1ns/1ps
// Staggered byte pipeline stage
module prfByteStage
	import prfPkg::*;
#(
	parameter int numLanes = NUM_LANES_DEF,
	parameter int numRegs  = NUM_REGS_DEF,
	parameter int byteIdx  = 0
)
(
	input  logic                clk,
	input  logic                rstN_i,

	// Requests arriving at this byte
	input  physTag_t            src1Tag_i  [0:numLanes-1],
	input  physTag_t            src2Tag_i  [0:numLanes-1],
	input  logic [numLanes-1:0] wrEn_i,
	input  physTag_t            wrTag_i    [0:numLanes-1],
	input  regWord_t            wrWord_i   [0:numLanes-1],

	input  logic                dbgWe_i,
	input  physTag_t            dbgTag_i,
	input  regByte_t            dbgByte_i,

	// This stage's read byte
	output regByte_t            src1Byte_o [0:numLanes-1],
	output regByte_t            src2Byte_o [0:numLanes-1],
	output regByte_t            dbgByte_o,

	// Registered requests for the next byte
	output physTag_t            src1Tag_o  [0:numLanes-1],
	output physTag_t            src2Tag_o  [0:numLanes-1],
	output logic [numLanes-1:0] wrEn_o,
	output physTag_t            wrTag_o    [0:numLanes-1],
	output regWord_t            wrWord_o   [0:numLanes-1]
);

	// Only bytes above this one travel on
	localparam regWord_t fwdMask =
		regWord_t'(64'hFFFF_FFFF_FFFF_FFFF << (BYTE_W * (byteIdx + 1)));

	regByte_t wrByte [0:numLanes-1];

	always_comb
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			wrByte[l] = wrWord_i[l][byteIdx*BYTE_W +: BYTE_W];  // Own byte of the bypass word
		end
	end

	prfByteBank #(
		.numLanes  (numLanes),
		.numRegs   (numRegs)
	) bank (
		.clk       (clk),
		.rstN_i    (rstN_i),
		.rdTag1_i  (src1Tag_i),
		.rdTag2_i  (src2Tag_i),
		.rdByte1_o (src1Byte_o),
		.rdByte2_o (src2Byte_o),
		.wrEn_i    (wrEn_i),
		.wrTag_i   (wrTag_i),
		.wrByte_i  (wrByte),
		.dbgWe_i   (dbgWe_i),
		.dbgTag_i  (dbgTag_i),
		.dbgByte_i (dbgByte_i),
		.dbgByte_o (dbgByte_o)
	);

	// Control side of the stagger pipeline
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			wrEn_o <= '0;
			for (int l = 0; l < numLanes; l++)
			begin
				src1Tag_o[l] <= '0;
				src2Tag_o[l] <= '0;
			end
		end
		else
		begin
			wrEn_o <= wrEn_i;
			for (int l = 0; l < numLanes; l++)
			begin
				src1Tag_o[l] <= src1Tag_i[l];
				src2Tag_o[l] <= src2Tag_i[l];
			end
		end
	end

	// Write payload, qualified by wrEn_o
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			wrTag_o[l]  <= wrTag_i[l];
			wrWord_o[l] <= wrWord_i[l] & fwdMask;
		end
	end

endmodule

//--- common/prfPkg.sv
// Register file shared definitions
package prfPkg;

	// Default configuration, set at the top level
	localparam int NUM_LANES_DEF = 4;
	localparam int NUM_REGS_DEF  = 64;

	// Four byte banks per register, one per pipeline stage
	localparam int BYTES_PER_REG = 4;

	localparam int BYTE_W     = 8;
	localparam int TAG_W      = 6;  // Covers NUM_REGS_DEF
	localparam int BYTE_SEL_W = $clog2(BYTES_PER_REG);

	// One byte of register data
	typedef logic [BYTE_W-1:0] regByte_t;

	// Full register value
	typedef logic [BYTES_PER_REG*BYTE_W-1:0] regWord_t;

	// Physical register tag
	typedef logic [TAG_W-1:0] physTag_t;

	// Byte index within a register
	typedef logic [BYTE_SEL_W-1:0] byteSel_t;

	// Debug address, byte index above the tag
	typedef logic [BYTE_SEL_W+TAG_W-1:0] dbgAddr_t;

	// Debug slave states
	typedef enum logic
	{
		dbgIdle,
		dbgAck
	} dbgState_t;

endpackage

//--- design/phyRegFile.sv
`timescale 1ns/1ps
// Byte-staggered physical register file
module phyRegFile
	import prfPkg::*;
#(
	parameter int numLanes = NUM_LANES_DEF,
	parameter int numRegs  = NUM_REGS_DEF
)
(
	input  logic                clk,
	input  logic                rstN_i,

	// Source tags per lane
	input  physTag_t            src1Tag_i  [0:numLanes-1],
	input  physTag_t            src2Tag_i  [0:numLanes-1],

	// Bypass packets
	input  logic [numLanes-1:0] bypValid_i,
	input  physTag_t            bypTag_i   [0:numLanes-1],
	input  regWord_t            bypData_i  [0:numLanes-1],

	// Read bytes, indexed by byte then lane
	output regByte_t            src1Byte_o [0:BYTES_PER_REG-1][0:numLanes-1],
	output regByte_t            src2Byte_o [0:BYTES_PER_REG-1][0:numLanes-1],

	// Wishbone debug
	input  logic                wbCyc_i,
	input  logic                wbStb_i,
	input  logic                wbWe_i,
	input  dbgAddr_t            wbAdr_i,
	input  regByte_t            wbDat_i,
	output regByte_t            wbDat_o,
	output logic                wbAck_o
);

	// Requests entering each byte stage
	physTag_t            src1TagPipe [0:BYTES_PER_REG-1][0:numLanes-1];
	physTag_t            src2TagPipe [0:BYTES_PER_REG-1][0:numLanes-1];
	logic [numLanes-1:0] wrEnPipe    [0:BYTES_PER_REG-1];
	physTag_t            wrTagPipe   [0:BYTES_PER_REG-1][0:numLanes-1];
	regWord_t            wrWordPipe  [0:BYTES_PER_REG-1][0:numLanes-1];

	logic [BYTES_PER_REG-1:0] dbgWe;
	physTag_t                 dbgTag;
	regByte_t                 dbgWrByte;
	regByte_t                 dbgRdByte [0:BYTES_PER_REG-1];

	// Byte 0 sees the lane requests directly
	assign src1TagPipe[0] = src1Tag_i;
	assign src2TagPipe[0] = src2Tag_i;
	assign wrEnPipe[0]    = bypValid_i;
	assign wrTagPipe[0]   = bypTag_i;
	assign wrWordPipe[0]  = bypData_i;

	for (genvar k = 0; k < BYTES_PER_REG; k++)
	begin : gStage
		if (k < BYTES_PER_REG - 1)
		begin : gFwd
			prfByteStage #(
				.numLanes   (numLanes),
				.numRegs    (numRegs),
				.byteIdx    (k)
			) stage (
				.clk        (clk),
				.rstN_i     (rstN_i),
				.src1Tag_i  (src1TagPipe[k]),
				.src2Tag_i  (src2TagPipe[k]),
				.wrEn_i     (wrEnPipe[k]),
				.wrTag_i    (wrTagPipe[k]),
				.wrWord_i   (wrWordPipe[k]),
				.dbgWe_i    (dbgWe[k]),
				.dbgTag_i   (dbgTag),
				.dbgByte_i  (dbgWrByte),
				.src1Byte_o (src1Byte_o[k]),
				.src2Byte_o (src2Byte_o[k]),
				.dbgByte_o  (dbgRdByte[k]),
				.src1Tag_o  (src1TagPipe[k+1]),
				.src2Tag_o  (src2TagPipe[k+1]),
				.wrEn_o     (wrEnPipe[k+1]),
				.wrTag_o    (wrTagPipe[k+1]),
				.wrWord_o   (wrWordPipe[k+1])
			);
		end
		else
		begin : gLast
			// End of the chain
			prfByteStage #(
				.numLanes   (numLanes),
				.numRegs    (numRegs),
				.byteIdx    (k)
			) stage (
				.clk        (clk),
				.rstN_i     (rstN_i),
				.src1Tag_i  (src1TagPipe[k]),
				.src2Tag_i  (src2TagPipe[k]),
				.wrEn_i     (wrEnPipe[k]),
				.wrTag_i    (wrTagPipe[k]),
				.wrWord_i   (wrWordPipe[k]),
				.dbgWe_i    (dbgWe[k]),
				.dbgTag_i   (dbgTag),
				.dbgByte_i  (dbgWrByte),
				.src1Byte_o (src1Byte_o[k]),
				.src2Byte_o (src2Byte_o[k]),
				.dbgByte_o  (dbgRdByte[k]),
				.src1Tag_o  (),
				.src2Tag_o  (),
				.wrEn_o     (),
				.wrTag_o    (),
				.wrWord_o   ()
			);
		end
	end

	prfDebugWb debugWb (
		.clk         (clk),
		.rstN_i      (rstN_i),
		.wbCyc_i     (wbCyc_i),
		.wbStb_i     (wbStb_i),
		.wbWe_i      (wbWe_i),
		.wbAdr_i     (wbAdr_i),
		.wbDat_i     (wbDat_i),
		.wbDat_o     (wbDat_o),
		.wbAck_o     (wbAck_o),
		.dbgWe_o     (dbgWe),
		.dbgTag_o    (dbgTag),
		.dbgByte_o   (dbgWrByte),
		.dbgRdByte_i (dbgRdByte)
	);

endmodule

//--- design/prfDebugWb.sv
`timescale 1ns/1ps
// Wishbone debug slave
module prfDebugWb
	import prfPkg::*;
(
	input  logic                     clk,
	input  logic                     rstN_i,

	// Wishbone classic slave
	input  logic                     wbCyc_i,
	input  logic                     wbStb_i,
	input  logic                     wbWe_i,
	input  dbgAddr_t                 wbAdr_i,
	input  regByte_t                 wbDat_i,
	output regByte_t                 wbDat_o,
	output logic                     wbAck_o,

	// Towards the byte banks
	output logic [BYTES_PER_REG-1:0] dbgWe_o,
	output physTag_t                 dbgTag_o,
	output regByte_t                 dbgByte_o,
	input  regByte_t                 dbgRdByte_i [0:BYTES_PER_REG-1]
);

	dbgState_t state;
	logic      accept;
	byteSel_t  reqByte;

	assign reqByte = wbAdr_i[TAG_W +: BYTE_SEL_W];
	assign accept  = wbCyc_i && wbStb_i && (state == dbgIdle);

	assign dbgTag_o  = wbAdr_i[TAG_W-1:0];
	assign dbgByte_o = wbDat_i;

	// One-hot bank select, only in the accept cycle
	always_comb
	begin
		dbgWe_o = '0;
		if (accept && wbWe_i)
		begin
			dbgWe_o[reqByte] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			state <= dbgIdle;
		end
		else
		begin
			case (state)
				dbgIdle:
				begin
					if (accept)
					begin
						state <= dbgAck;
					end
				end
				dbgAck: state <= dbgIdle;  // Back to idle before the next request
				default: state <= dbgIdle;
			endcase
		end
	end

	// Byte as it stood in the request cycle
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wbDat_o <= dbgRdByte_i[reqByte];
		end
	end

	assign wbAck_o = (state == dbgAck);

endmodule

//--- testbench/phyRegFileTb.sv
`timescale 1ns/1ps
// Register file testbench
module phyRegFileTb
	import prfPkg::*;
();

	localparam int NL          = NUM_LANES_DEF;
	localparam int NR          = NUM_REGS_DEF;
	localparam int NB          = BYTES_PER_REG;
	localparam int ACK_TIMEOUT = 20;

	logic                clk;
	logic                rstN;
	physTag_t            src1Tag  [0:NL-1];
	physTag_t            src2Tag  [0:NL-1];
	logic [NL-1:0]       bypValid;
	physTag_t            bypTag   [0:NL-1];
	regWord_t            bypData  [0:NL-1];
	regByte_t            src1Byte [0:NB-1][0:NL-1];
	regByte_t            src2Byte [0:NB-1][0:NL-1];
	logic                wbCyc;
	logic                wbStb;
	logic                wbWe;
	dbgAddr_t            wbAdr;
	regByte_t            wbDat;
	regByte_t            wbDatOut;
	logic                wbAck;

	// Values for the next cycle's drive
	physTag_t            nxtSrc1  [0:NL-1];
	physTag_t            nxtSrc2  [0:NL-1];
	logic [NL-1:0]       nxtValid;
	physTag_t            nxtTag   [0:NL-1];
	regWord_t            nxtData  [0:NL-1];
	logic                nxtCyc;
	logic                nxtStb;
	logic                nxtWe;
	dbgAddr_t            nxtAdr;
	regByte_t            nxtDat;

	// Reference model and expected read history
	regByte_t            model    [0:NR-1][0:NB-1];
	regByte_t            exp1     [0:NB-1][0:NL-1][0:NB-1];
	regByte_t            exp2     [0:NB-1][0:NL-1][0:NB-1];
	logic                histValid [0:NB-1];
	int                  cycCnt;
	logic                checkReads;
	logic                ackSeen;
	regByte_t            rdSample;
	string               testName;
	logic [31:0]         lcgState;

	phyRegFile #(
		.numLanes   (NL),
		.numRegs    (NR)
	) uut (
		.clk        (clk),
		.rstN_i     (rstN),
		.src1Tag_i  (src1Tag),
		.src2Tag_i  (src2Tag),
		.bypValid_i (bypValid),
		.bypTag_i   (bypTag),
		.bypData_i  (bypData),
		.src1Byte_o (src1Byte),
		.src2Byte_o (src2Byte),
		.wbCyc_i    (wbCyc),
		.wbStb_i    (wbStb),
		.wbWe_i     (wbWe),
		.wbAdr_i    (wbAdr),
		.wbDat_i    (wbDat),
		.wbDat_o    (wbDatOut),
		.wbAck_o    (wbAck)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic failRun();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic checkByte(input string what, input regByte_t expV, input regByte_t actV);
		if (actV !== expV)
		begin
			$display("ERR %s: %s expected %h actual %h", testName, what, expV, actV);
			failRun();
		end
	endtask

	task automatic checkAck(input string what, input logic expV, input logic actV);
		if (actV !== expV)
		begin
			$display("ERR %s: %s expected %b actual %b", testName, what, expV, actV);
			failRun();
		end
	endtask

	// One clock: drive, snapshot, apply writes, then sample late in the cycle
	task automatic stepCycle();
		int slot;
		int s;
		@(posedge clk);
		#1;
		src1Tag  = nxtSrc1;
		src2Tag  = nxtSrc2;
		bypValid = nxtValid;
		bypTag   = nxtTag;
		bypData  = nxtData;
		wbCyc    = nxtCyc;
		wbStb    = nxtStb;
		wbWe     = nxtWe;
		wbAdr    = nxtAdr;
		wbDat    = nxtDat;
		slot = cycCnt % NB;
		histValid[slot] = checkReads;
		for (int l = 0; l < NL; l++)
		begin
			for (int k = 0; k < NB; k++)
			begin
				exp1[slot][l][k] = model[nxtSrc1[l]][k];  // Before this cycle's writes
				exp2[slot][l][k] = model[nxtSrc2[l]][k];
			end
		end
		for (int l = 0; l < NL; l++)
		begin
			if (nxtValid[l])
			begin
				for (int k = 0; k < NB; k++)
				begin
					model[nxtTag[l]][k] = nxtData[l][k*8 +: 8];  // Higher lane lands last
				end
			end
		end
		#7;
		for (int age = 0; age < NB; age++)
		begin
			s = (cycCnt + NB - age) % NB;
			if (histValid[s])
			begin
				for (int l = 0; l < NL; l++)
				begin
					checkByte($sformatf("src1 lane %0d byte %0d", l, age),
						exp1[s][l][age], src1Byte[age][l]);
					checkByte($sformatf("src2 lane %0d byte %0d", l, age),
						exp2[s][l][age], src2Byte[age][l]);
				end
			end
		end
		ackSeen  = wbAck;
		rdSample = wbDatOut;
		if (uut.chk.failCount != 0)
		begin
			$display("A bound assertion failed during %s", testName);
			failRun();
		end
		cycCnt++;
	endtask

	task automatic randomReads();
		for (int l = 0; l < NL; l++)
		begin
			nxtSrc1[l] = physTag_t'(nextRand() >> 26);
			nxtSrc2[l] = physTag_t'(nextRand() >> 26);
		end
	endtask

	task automatic noWrites();
		nxtValid = '0;
	endtask

	task automatic randomWrites(input logic allValid);
		logic [31:0] r;
		for (int l = 0; l < NL; l++)
		begin
			r = nextRand();
			nxtValid[l] = allValid | r[31];
			nxtTag[l]   = r[29:24];
			nxtData[l]  = nextRand();
		end
	endtask

	task automatic drain();
		noWrites();
		randomReads();
		repeat (NB) stepCycle();
	endtask

	task automatic wbAccess(input logic we, input physTag_t tag, input byteSel_t sel,
		input regByte_t data, output regByte_t rd);
		int waitCnt;
		nxtCyc = 1'b1;
		nxtStb = 1'b1;
		nxtWe  = we;
		nxtAdr = {sel, tag};
		nxtDat = data;
		stepCycle();  // Accept cycle
		checkAck("ack in request cycle", 1'b0, ackSeen);
		nxtCyc  = 1'b0;
		nxtStb  = 1'b0;
		nxtWe   = 1'b0;
		waitCnt = 0;
		stepCycle();
		while (!ackSeen && waitCnt < ACK_TIMEOUT)
		begin
			stepCycle();
			waitCnt++;
		end
		if (!ackSeen)
		begin
			$display("Timed out waiting for the Wishbone ack during %s", testName);
			failRun();
		end
		rd = rdSample;
		stepCycle();
		checkAck("ack after single request", 1'b0, ackSeen);
	endtask

	initial
	begin
		physTag_t t;
		regWord_t old;
		regByte_t rd;
		byteSel_t sel;
		regByte_t db;
		clk        = 1'b0;
		rstN       = 1'b0;
		lcgState   = 32'hee1d24fe;
		cycCnt     = 0;
		checkReads = 1'b1;
		testName   = "reset";
		nxtValid   = '0;
		nxtCyc     = 1'b0;
		nxtStb     = 1'b0;
		nxtWe      = 1'b0;
		nxtAdr     = '0;
		nxtDat     = '0;
		for (int l = 0; l < NL; l++)
		begin
			nxtSrc1[l] = '0;
			nxtSrc2[l] = '0;
			nxtTag[l]  = '0;
			nxtData[l] = '0;
		end
		for (int r = 0; r < NR; r++)
		begin
			for (int k = 0; k < NB; k++)
			begin
				model[r][k] = '0;
			end
		end
		for (int s = 0; s < NB; s++)
		begin
			histValid[s] = 1'b0;
		end
		src1Tag  = nxtSrc1;
		src2Tag  = nxtSrc2;
		bypValid = '0;
		bypTag   = nxtTag;
		bypData  = nxtData;
		wbCyc    = 1'b0;
		wbStb    = 1'b0;
		wbWe     = 1'b0;
		wbAdr    = '0;
		wbDat    = '0;
		repeat (2) @(posedge clk);
		#1 rstN = 1'b1;

		testName = "reads after reset";
		noWrites();
		for (int i = 0; i < 32; i++)
		begin
			randomReads();
			stepCycle();
		end

		testName = "random writes then reads";
		for (int i = 0; i < 48; i++)
		begin
			nxtSrc1 = nxtTag;  // Chase the previous cycle's writes
			randomWrites(1'b1);
			nxtSrc2[0] = nxtTag[0];
			stepCycle();
		end
		noWrites();
		for (int i = 0; i < NR / (2 * NL); i++)
		begin
			for (int l = 0; l < NL; l++)
			begin
				nxtSrc1[l] = physTag_t'(i * 2 * NL + l);
				nxtSrc2[l] = physTag_t'(i * 2 * NL + NL + l);
			end
			stepCycle();
		end
		drain();

		testName = "read during write";
		for (int i = 0; i < 8; i++)
		begin
			t   = physTag_t'(nextRand() >> 26);
			old = {model[t][3], model[t][2], model[t][1], model[t][0]};
			randomReads();
			noWrites();
			nxtValid[i % NL] = 1'b1;
			nxtTag[i % NL]   = t;
			nxtData[i % NL]  = ~old;  // Old and new differ in every byte
			nxtSrc1[0]       = t;
			nxtSrc2[NL-1]    = t;
			stepCycle();
			noWrites();
			nxtSrc1[0] = t;
			stepCycle();
		end
		drain();

		testName = "same tag multi lane write";
		for (int i = 0; i < 8; i++)
		begin
			t = physTag_t'(nextRand() >> 26);
			randomWrites(1'b1);
			for (int l = 0; l < NL; l++)
			begin
				nxtTag[l] = t;
			end
			stepCycle();
			noWrites();
			nxtSrc1[0] = t;
			nxtSrc2[1] = t;
			stepCycle();
		end
		drain();

		testName = "wishbone debug";
		for (int i = 0; i < 6; i++)
		begin
			checkReads = 1'b0;  // Bytes in flight may straddle the debug commit
			noWrites();
			repeat (NB) stepCycle();
			t   = physTag_t'(nextRand() >> 26);
			sel = byteSel_t'(nextRand() >> 30);
			db  = regByte_t'(nextRand() >> 24);
			wbAccess(1'b1, t, sel, db, rd);
			model[t][sel] = db;
			checkReads = 1'b1;
			for (int j = 0; j < NB; j++)
			begin
				randomReads();
				nxtSrc1[0] = t;
				stepCycle();
			end
			wbAccess(1'b0, t, sel, 8'h00, rd);
			checkByte("debug read back", model[t][sel], rd);
			t   = physTag_t'(nextRand() >> 26);
			sel = byteSel_t'(nextRand() >> 30);
			wbAccess(1'b0, t, sel, 8'h00, rd);
			checkByte("debug read", model[t][sel], rd);
		end
		drain();

		testName = "stress";
		for (int i = 0; i < 400; i++)
		begin
			randomReads();
			randomWrites(1'b0);
			stepCycle();
		end
		drain();

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- testbench/phyRegFile_chk.sv
`timescale 1ns/1ps
// Wishbone ack checks
module phyRegFile_chk
(
	input logic clk,
	input logic rstN_i,
	input logic wbCyc_i,
	input logic wbStb_i,
	input logic wbAck_o
);

	int failCount = 0;  // Assertion failures so far

	// Slave passes through idle between acks
	ackSingle: assert property (@(posedge clk) disable iff (!rstN_i) wbAck_o |=> !wbAck_o)
	else
	begin
		failCount++;
		$error("Wishbone ack high for two cycles running");
	end

	ackAfterStb: assert property (@(posedge clk) disable iff (!rstN_i)
		$rose(wbAck_o) |-> $past(wbCyc_i && wbStb_i))
	else
	begin
		failCount++;
		$error("Wishbone ack rose without a strobe");
	end

	// Covers the reset cycles and the first cycle after
	ackReset: assert property (@(posedge clk) !rstN_i |=> !wbAck_o)
	else
	begin
		failCount++;
		$error("Wishbone ack high around reset");
	end

endmodule

bind phyRegFile phyRegFile_chk chk (
	.clk     (clk),
	.rstN_i  (rstN_i),
	.wbCyc_i (wbCyc_i),
	.wbStb_i (wbStb_i),
	.wbAck_o (wbAck_o)
);

//--- verilog.f
common/prfPkg.sv
byteStage/prfByteBank.sv
byteStage/prfByteStage.sv
design/prfDebugWb.sv
design/phyRegFile.sv
testbench/phyRegFile_chk.sv
testbench/phyRegFileTb.sv
